//--- rtl/shim_pkg.sv
/*
 * Shared types and the fixed address map of the core data shim.
 * Every RTL module and the testbench import from here.
 */
package shim_pkg;

  // Widths that carry a meaning
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  // Sized for up to 8 outstanding reads
  typedef logic [2:0]  rob_id_t;

  // Core request, the ID is filled in by the shim
  typedef struct packed {
    addr_t   addr;
    logic    write;
    data_t   data;
    strb_t   strb;
    rob_id_t id;
  } dreq_t;

  // Read response, returned by a bank or the SoC
  typedef struct packed {
    data_t   data;
    rob_id_t id;
    logic    error;
  } dresp_t;

  // TCDM window
  // anything outside of it is routed to the SoC port
  localparam addr_t TcdmBase = 32'h0000_0000;
  localparam addr_t TcdmSize = 32'h0000_1000;

  // Bank response register
  typedef enum logic {
    idle,
    resp_pending
  } target_state_e;

endpackage

//--- rtl/reorder_buffer.sv
/*
 * Reorder buffer for read responses. IDs are handed out in issue order,
 * responses are stored by ID and leave in the same order, head falls through.
 */
module reorder_buffer #(
  parameter int unsigned MaxOutstandingReads = 8
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // ID allocation
  input  logic              id_req_i,
  output shim_pkg::rob_id_t id_o,
  output logic              full_o,
  // Response write
  input  logic              push_i,
  input  shim_pkg::dresp_t  resp_i,
  // In-order read
  output shim_pkg::dresp_t  resp_o,
  output logic              valid_o,
  input  logic              pop_i
);
  import shim_pkg::*;

  localparam int unsigned IdWidth  = $clog2(MaxOutstandingReads);
  localparam int unsigned CntWidth = $clog2(MaxOutstandingReads + 1);

  logic [IdWidth-1:0]             wr_ptr_q;
  logic [IdWidth-1:0]             rd_ptr_q;
  logic [CntWidth-1:0]            count_q;
  logic [MaxOutstandingReads-1:0] slot_valid_q;
  logic [MaxOutstandingReads-1:0] slot_error_q;
  data_t                          slot_data_q [MaxOutstandingReads];

  logic [IdWidth-1:0] push_id;
  logic               head_hit;
  logic               pop;

  // Depth need not be a power of two
  function automatic logic [IdWidth-1:0] next_ptr(input logic [IdWidth-1:0] ptr);
    if (ptr == IdWidth'(MaxOutstandingReads - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push_id  = resp_i.id[IdWidth-1:0];
  assign head_hit = push_i && (push_id == rd_ptr_q);
  assign valid_o  = slot_valid_q[rd_ptr_q] || head_hit;
  assign pop      = pop_i && valid_o;

  assign id_o   = rob_id_t'(wr_ptr_q);
  assign full_o = (count_q == CntWidth'(MaxOutstandingReads));

  always_comb begin
    resp_o.id = rob_id_t'(rd_ptr_q);
    if (slot_valid_q[rd_ptr_q]) begin
      resp_o.data  = slot_data_q[rd_ptr_q];
      resp_o.error = slot_error_q[rd_ptr_q];
    end else begin
      // Head arriving this cycle
      resp_o.data  = resp_i.data;
      resp_o.error = resp_i.error;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      slot_valid_q <= '0;
    end else begin
      if (id_req_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({id_req_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      if (push_i) begin
        slot_valid_q[push_id] <= 1'b1;
      end
      // Clearing wins so a fall-through push is never kept
      if (pop) begin
        slot_valid_q[rd_ptr_q] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      slot_data_q[push_id]  <= resp_i.data;
      slot_error_q[push_id] <= resp_i.error;
    end
  end

endmodule

//--- rtl/addr_demux.sv
/*
 * Routes each request to a TCDM bank or the SoC port by address, and merges
 * target responses back with a round-robin choice, one per cycle.
 */
module addr_demux #(
  parameter int unsigned NrTCDM = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  // From the shim
  input  shim_pkg::dreq_t              req_i,
  input  logic                         req_valid_i,
  output logic                         req_ready_o,
  output shim_pkg::dresp_t             resp_o,
  output logic                         resp_valid_o,
  // To the targets, SoC at the highest index
  output shim_pkg::dreq_t  [NrTCDM:0]  tgt_req_o,
  output logic             [NrTCDM:0]  tgt_valid_o,
  input  logic             [NrTCDM:0]  tgt_ready_i,
  input  shim_pkg::dresp_t [NrTCDM:0]  tgt_resp_i,
  input  logic             [NrTCDM:0]  tgt_resp_valid_i,
  output logic             [NrTCDM:0]  tgt_resp_ready_o
);
  import shim_pkg::*;

  localparam int unsigned NrPorts  = NrTCDM + 1;
  localparam int unsigned SelWidth = $clog2(NrPorts);
  localparam int unsigned SocPort  = NrTCDM;

  logic                in_tcdm;
  logic [SelWidth-1:0] req_sel;
  logic [SelWidth-1:0] resp_sel;
  logic [SelWidth-1:0] rr_q;
  logic                resp_found;

  assign in_tcdm = (req_i.addr >= TcdmBase) && (req_i.addr < TcdmBase + TcdmSize);

  // Word interleaved over the banks
  always_comb begin
    if (in_tcdm) begin
      req_sel = SelWidth'((req_i.addr >> 2) & addr_t'(NrTCDM - 1));
    end else begin
      req_sel = SelWidth'(SocPort);
    end
  end

  // Payload goes to all ports, valid only to the selected one
  always_comb begin
    tgt_valid_o = '0;
    for (int unsigned p = 0; p < NrPorts; p++) begin
      tgt_req_o[p] = req_i;
    end
    tgt_valid_o[req_sel] = req_valid_i;
  end

  assign req_ready_o = tgt_ready_i[req_sel];

  // First valid response at or after the pointer
  always_comb begin
    int unsigned idx;
    resp_found = 1'b0;
    resp_sel   = rr_q;
    for (int unsigned i = 0; i < NrPorts; i++) begin
      idx = rr_q + i;
      if (idx >= NrPorts) begin
        idx = idx - NrPorts;
      end
      if (!resp_found && tgt_resp_valid_i[idx]) begin
        resp_found = 1'b1;
        resp_sel   = SelWidth'(idx);
      end
    end
  end

  assign resp_o       = tgt_resp_i[resp_sel];
  assign resp_valid_o = resp_found;

  // Shim always takes the response, so ready goes to the winner only
  always_comb begin
    tgt_resp_ready_o = '0;
    tgt_resp_ready_o[resp_sel] = resp_found;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (resp_found) begin
      if (resp_sel == SelWidth'(NrPorts - 1)) begin
        rr_q <= '0;
      end else begin
        rr_q <= resp_sel + 1'b1;
      end
    end
  end

endmodule

//--- rtl/tcdm_bank.sv
/*
 * One TCDM bank. Byte-strobed writes, reads answered one cycle later
 * from a response register that holds until accepted.
 */
module tcdm_bank #(
  parameter int unsigned NrTCDM    = 2,
  parameter int unsigned BankWords = 512
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  shim_pkg::dreq_t  req_i,
  input  logic             req_valid_i,
  output logic             req_ready_o,
  output shim_pkg::dresp_t resp_o,
  output logic             resp_valid_o,
  input  logic             resp_ready_i
);
  import shim_pkg::*;

  localparam int unsigned IdxWidth = $clog2(BankWords);
  // Skip byte offset and bank select bits
  localparam int unsigned IdxShift = 2 + $clog2(NrTCDM);

  data_t               mem_q [BankWords];
  data_t               rdata_q;
  rob_id_t             rid_q;
  target_state_e       state_q;
  logic [IdxWidth-1:0] word_idx;
  logic                req_fire;

  assign word_idx     = IdxWidth'((req_i.addr - TcdmBase) >> IdxShift);
  assign req_ready_o  = (state_q == idle) || resp_ready_i;
  assign req_fire     = req_valid_i && req_ready_o;
  assign resp_valid_o = (state_q == resp_pending);

  assign resp_o.data  = rdata_q;
  assign resp_o.id    = rid_q;
  assign resp_o.error = 1'b0;

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      if (req_i.write) begin
        for (int unsigned b = 0; b < $bits(strb_t); b++) begin
          if (req_i.strb[b]) begin
            mem_q[word_idx][8*b +: 8] <= req_i.data[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[word_idx];
        rid_q   <= req_i.id;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= idle;
    end else if (req_fire && !req_i.write) begin
      state_q <= resp_pending;
    end else if (resp_ready_i) begin
      state_q <= idle;
    end
  end

endmodule

//--- rtl/tcdm_shim.sv
/*
 * Core-facing data shim. Tags reads with a reorder ID, routes requests
 * through the address demux and returns read data in issue order.
 */
module tcdm_shim #(
  parameter int unsigned NrTCDM              = 2,
  parameter int unsigned MaxOutstandingReads = 8
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  // Core
  input  shim_pkg::dreq_t                   data_q_i,
  input  logic                              data_qvalid_i,
  output logic                              data_qready_o,
  output shim_pkg::dresp_t                  data_p_o,
  output logic                              data_pvalid_o,
  input  logic                              data_pready_i,
  // TCDM banks
  output shim_pkg::dreq_t  [NrTCDM-1:0]     tcdm_req_o,
  output logic             [NrTCDM-1:0]     tcdm_req_valid_o,
  input  logic             [NrTCDM-1:0]     tcdm_req_ready_i,
  input  shim_pkg::dresp_t [NrTCDM-1:0]     tcdm_resp_i,
  input  logic             [NrTCDM-1:0]     tcdm_resp_valid_i,
  output logic             [NrTCDM-1:0]     tcdm_resp_ready_o,
  // SoC
  output shim_pkg::dreq_t                   soc_req_o,
  output logic                              soc_qvalid_o,
  input  logic                              soc_qready_i,
  input  shim_pkg::dresp_t                  soc_resp_i,
  input  logic                              soc_pvalid_i,
  output logic                              soc_pready_o
);
  import shim_pkg::*;

  dreq_t              demux_req;
  logic               demux_ready;
  dresp_t             demux_resp;
  logic               demux_resp_valid;
  logic               rob_full;
  rob_id_t            rob_id;
  logic               read_blocked;
  logic               id_req;

  dreq_t  [NrTCDM:0]  tgt_req;
  logic   [NrTCDM:0]  tgt_valid;
  logic   [NrTCDM:0]  tgt_resp_ready;

  always_comb begin
    demux_req    = data_q_i;
    demux_req.id = data_q_i.write ? rob_id_t'(0) : rob_id;
  end

  // Only reads need a free reorder slot
  assign read_blocked  = !data_q_i.write && rob_full;
  assign data_qready_o = demux_ready && !read_blocked;
  assign id_req        = data_qvalid_i && data_qready_o && !data_q_i.write;

  reorder_buffer #(
    .MaxOutstandingReads(MaxOutstandingReads)
  ) i_reorder_buffer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .id_req_i(id_req),
    .id_o    (rob_id),
    .full_o  (rob_full),
    .push_i  (demux_resp_valid),
    .resp_i  (demux_resp),
    .resp_o  (data_p_o),
    .valid_o (data_pvalid_o),
    .pop_i   (data_pready_i)
  );

  addr_demux #(
    .NrTCDM(NrTCDM)
  ) i_addr_demux (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .req_i           (demux_req),
    .req_valid_i     (data_qvalid_i && !read_blocked),
    .req_ready_o     (demux_ready),
    .resp_o          (demux_resp),
    .resp_valid_o    (demux_resp_valid),
    .tgt_req_o       (tgt_req),
    .tgt_valid_o     (tgt_valid),
    .tgt_ready_i     ({soc_qready_i, tcdm_req_ready_i}),
    .tgt_resp_i      ({soc_resp_i, tcdm_resp_i}),
    .tgt_resp_valid_i({soc_pvalid_i, tcdm_resp_valid_i}),
    .tgt_resp_ready_o(tgt_resp_ready)
  );

  // Banks take the low ports, SoC the top one
  assign tcdm_req_o        = tgt_req[NrTCDM-1:0];
  assign tcdm_req_valid_o  = tgt_valid[NrTCDM-1:0];
  assign tcdm_resp_ready_o = tgt_resp_ready[NrTCDM-1:0];
  assign soc_req_o         = tgt_req[NrTCDM];
  assign soc_qvalid_o      = tgt_valid[NrTCDM];
  assign soc_pready_o      = tgt_resp_ready[NrTCDM];

endmodule

//--- rtl/shim_subsystem.sv
/*
 * Cluster data subsystem: the core shim with its TCDM banks.
 * Core and SoC ports are brought out to the top.
 */
module shim_subsystem #(
  parameter int unsigned NrTCDM              = 2,
  parameter int unsigned MaxOutstandingReads = 8,
  parameter int unsigned BankWords           = 512
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  // Core
  input  shim_pkg::dreq_t  data_q_i,
  input  logic             data_qvalid_i,
  output logic             data_qready_o,
  output shim_pkg::dresp_t data_p_o,
  output logic             data_pvalid_o,
  input  logic             data_pready_i,
  // SoC
  output shim_pkg::dreq_t  soc_req_o,
  output logic             soc_qvalid_o,
  input  logic             soc_qready_i,
  input  shim_pkg::dresp_t soc_resp_i,
  input  logic             soc_pvalid_i,
  output logic             soc_pready_o
);
  import shim_pkg::*;

  dreq_t  [NrTCDM-1:0] tcdm_req;
  logic   [NrTCDM-1:0] tcdm_req_valid;
  logic   [NrTCDM-1:0] tcdm_req_ready;
  dresp_t [NrTCDM-1:0] tcdm_resp;
  logic   [NrTCDM-1:0] tcdm_resp_valid;
  logic   [NrTCDM-1:0] tcdm_resp_ready;

  tcdm_shim #(
    .NrTCDM             (NrTCDM),
    .MaxOutstandingReads(MaxOutstandingReads)
  ) i_tcdm_shim (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .data_q_i         (data_q_i),
    .data_qvalid_i    (data_qvalid_i),
    .data_qready_o    (data_qready_o),
    .data_p_o         (data_p_o),
    .data_pvalid_o    (data_pvalid_o),
    .data_pready_i    (data_pready_i),
    .tcdm_req_o       (tcdm_req),
    .tcdm_req_valid_o (tcdm_req_valid),
    .tcdm_req_ready_i (tcdm_req_ready),
    .tcdm_resp_i      (tcdm_resp),
    .tcdm_resp_valid_i(tcdm_resp_valid),
    .tcdm_resp_ready_o(tcdm_resp_ready),
    .soc_req_o        (soc_req_o),
    .soc_qvalid_o     (soc_qvalid_o),
    .soc_qready_i     (soc_qready_i),
    .soc_resp_i       (soc_resp_i),
    .soc_pvalid_i     (soc_pvalid_i),
    .soc_pready_o     (soc_pready_o)
  );

  for (genvar i = 0; i < NrTCDM; i++) begin : gen_bank
    tcdm_bank #(
      .NrTCDM   (NrTCDM),
      .BankWords(BankWords)
    ) i_tcdm_bank (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .req_i       (tcdm_req[i]),
      .req_valid_i (tcdm_req_valid[i]),
      .req_ready_o (tcdm_req_ready[i]),
      .resp_o      (tcdm_resp[i]),
      .resp_valid_o(tcdm_resp_valid[i]),
      .resp_ready_i(tcdm_resp_ready[i])
    );
  end

endmodule

//--- bench/tb_shim_subsystem.sv
/*
 * Testbench for the cluster data subsystem. Applies a table of core requests,
 * serves the SoC port and checks read data and order against a reference memory.
 */
module tb_shim_subsystem;
  timeunit 1ns;
  timeprecision 1ps;
  import shim_pkg::*;

  typedef struct packed {
    logic       write;
    addr_t      addr;
    data_t      data;
    strb_t      strb;
    logic [7:0] hold;
  } row_t;

  typedef struct packed {
    addr_t       addr;
    rob_id_t     id;
    logic [31:0] due;
  } soc_job_t;

  localparam int NumRows       = 28;
  localparam int MaxReads      = 8;
  localparam int TimeoutCycles = 40 * NumRows + 100;

  // write, address, data, strobe, cycles of data_pready_i low after acceptance
  row_t table_rows [NumRows] = '{
    '{1'b1, 32'h0000_0000, 32'h1122_3344, 4'hF, 8'd0},
    '{1'b1, 32'h0000_0004, 32'h5566_7788, 4'hF, 8'd0},
    '{1'b1, 32'h0000_0008, 32'h99AA_BBCC, 4'hF, 8'd0},
    '{1'b1, 32'h0000_000C, 32'hDDEE_FF00, 4'hF, 8'd0},
    '{1'b1, 32'h0000_0000, 32'hA0B0_C0D0, 4'h5, 8'd0},
    '{1'b1, 32'h0000_0004, 32'h0102_0304, 4'hA, 8'd0},
    '{1'b1, 32'h0000_000C, 32'h0000_EE00, 4'h2, 8'd0},
    '{1'b1, 32'h8000_0100, 32'hCAFE_F00D, 4'h3, 8'd0},
    '{1'b0, 32'h0000_0000, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b0, 32'h0000_0004, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b0, 32'h0000_000C, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b0, 32'h0000_0000, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b0, 32'h8000_0010, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b0, 32'h0000_0004, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b0, 32'h8000_0020, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b0, 32'h0000_0008, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b0, 32'h0000_000C, 32'h0000_0000, 4'hF, 8'd30},
    '{1'b0, 32'h8000_0034, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b0, 32'h0000_0000, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b0, 32'h0000_0004, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b0, 32'h8000_0048, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b0, 32'h0000_0008, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b0, 32'h0000_000C, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b0, 32'h8000_0050, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b0, 32'h0000_0000, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b0, 32'h0000_0004, 32'h0000_0000, 4'hF, 8'd0},
    '{1'b1, 32'h0000_010C, 32'h1234_5678, 4'hF, 8'd0},
    '{1'b0, 32'h0000_010C, 32'h0000_0000, 4'hF, 8'd0}
  };

  logic   clk_i;
  logic   rst_n_i;
  dreq_t  data_q_i;
  logic   data_qvalid_i;
  logic   data_qready_o;
  dresp_t data_p_o;
  logic   data_pvalid_o;
  logic   data_pready_i;
  dreq_t  soc_req_o;
  logic   soc_qvalid_o;
  logic   soc_qready_i;
  dresp_t soc_resp_i;
  logic   soc_pvalid_i;
  logic   soc_pready_o;

  data_t       ref_mem [addr_t];
  dresp_t      exp_q [$];
  soc_job_t    soc_jobs [$];
  row_t        cur_row;
  int unsigned cycle_cnt;
  int unsigned hold_left;
  int unsigned reads_issued;
  int unsigned reads_returned;
  int unsigned seed_value;

  shim_subsystem dut0 (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .data_q_i     (data_q_i),
    .data_qvalid_i(data_qvalid_i),
    .data_qready_o(data_qready_o),
    .data_p_o     (data_p_o),
    .data_pvalid_o(data_pvalid_o),
    .data_pready_i(data_pready_i),
    .soc_req_o    (soc_req_o),
    .soc_qvalid_o (soc_qvalid_o),
    .soc_qready_i (soc_qready_i),
    .soc_resp_i   (soc_resp_i),
    .soc_pvalid_i (soc_pvalid_i),
    .soc_pready_o (soc_pready_o)
  );

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("Error at %0t: %s expected %0h got %0h", $time, name, expected, actual);
      report_failure("Value mismatch");
    end
  endtask

  function automatic logic in_tcdm_window(input addr_t addr);
    return (addr >= TcdmBase) && (addr < TcdmBase + TcdmSize);
  endfunction

  // Updates the reference memory or queues the expected read response
  task automatic record_accept(input row_t row);
    addr_t  word_addr;
    data_t  word;
    dresp_t exp_resp;
    word_addr = row.addr & ~addr_t'(3);
    if (row.write && in_tcdm_window(row.addr)) begin
      word = ref_mem.exists(word_addr) ? ref_mem[word_addr] : '0;
      for (int b = 0; b < 4; b++) begin
        if (row.strb[b]) begin
          word[8*b +: 8] = row.data[8*b +: 8];
        end
      end
      ref_mem[word_addr] = word;
    end else if (!row.write) begin
      exp_resp.id = rob_id_t'(reads_issued % MaxReads);
      if (!in_tcdm_window(row.addr)) begin
        exp_resp.data  = row.addr ^ 32'hA5A5_0000;
        exp_resp.error = row.addr[4];
      end else if (ref_mem.exists(word_addr)) begin
        exp_resp.data  = ref_mem[word_addr];
        exp_resp.error = 1'b0;
      end else begin
        report_failure("Table reads a bank word that was never written");
      end
      exp_q.push_back(exp_resp);
      reads_issued++;
    end
    if (row.hold != 0) begin
      hold_left = row.hold;
    end
  endtask

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin : cycle_limit
    cycle_cnt = 0;
    while (cycle_cnt < TimeoutCycles) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    report_failure("Timeout: responses did not complete");
  end

  initial begin : pready_driver
    @(posedge rst_n_i);
    forever begin
      @(posedge clk_i);
      #10;
      if (hold_left > 0) begin
        data_pready_i = 1'b0;
        hold_left--;
      end else begin
        data_pready_i = 1'b1;
      end
    end
  end

  // Serves the SoC port in arrival order, each read after its own delay
  initial begin : soc_responder
    soc_job_t job;
    logic     soc_taken;
    soc_taken = 1'b0;
    @(posedge rst_n_i);
    forever begin
      @(posedge clk_i);
      #10;
      if (soc_pvalid_i && soc_taken) begin
        soc_pvalid_i = 1'b0;
      end
      soc_qready_i = ($urandom % 4) != 0;
      if (!soc_pvalid_i && soc_jobs.size() != 0 && cycle_cnt >= soc_jobs[0].due) begin
        job              = soc_jobs.pop_front();
        soc_resp_i.data  = job.addr ^ 32'hA5A5_0000;
        soc_resp_i.id    = job.id;
        soc_resp_i.error = job.addr[4];
        soc_pvalid_i     = 1'b1;
      end
      @(negedge clk_i);
      soc_taken = soc_pvalid_i && soc_pready_o;
      if (soc_qvalid_o && in_tcdm_window(soc_req_o.addr)) begin
        report_failure("Bank window address seen on the SoC port");
      end
      if (soc_qvalid_o && soc_qready_i) begin
        check_value("soc_req_o.addr", cur_row.addr, soc_req_o.addr);
        check_value("soc_req_o.write", cur_row.write, soc_req_o.write);
        check_value("soc_req_o.data", cur_row.data, soc_req_o.data);
        check_value("soc_req_o.strb", cur_row.strb, soc_req_o.strb);
        if (!soc_req_o.write) begin
          job.addr = soc_req_o.addr;
          job.id   = soc_req_o.id;
          job.due  = cycle_cnt + 3 + ($urandom % 10);
          soc_jobs.push_back(job);
        end
      end
    end
  end

  initial begin : response_checker
    dresp_t exp_resp;
    dresp_t held_resp;
    logic   held_valid;
    held_valid = 1'b0;
    held_resp  = '0;
    @(posedge rst_n_i);
    forever begin
      @(negedge clk_i);
      #1;
      // A stalled response must not move
      if (held_valid) begin
        check_value("data_pvalid_o", 1, data_pvalid_o);
        check_value("data_p_o", held_resp, data_p_o);
      end
      if (data_pvalid_o && data_pready_i) begin
        if (exp_q.size() == 0) begin
          report_failure("Response returned with no read outstanding");
        end else begin
          exp_resp = exp_q.pop_front();
          check_value("data_p_o.data", exp_resp.data, data_p_o.data);
          check_value("data_p_o.error", exp_resp.error, data_p_o.error);
          check_value("data_p_o.id", exp_resp.id, data_p_o.id);
          reads_returned++;
        end
      end
      if (reads_issued - reads_returned > MaxReads) begin
        report_failure("More than 8 reads outstanding");
      end
      held_valid = data_pvalid_o && !data_pready_i;
      held_resp  = data_p_o;
    end
  end

  initial begin : main_sequence
    row_t row;
    seed_value     = $urandom(32'h8f56);
    rst_n_i        = 1'b0;
    data_q_i       = '0;
    data_qvalid_i  = 1'b0;
    data_pready_i  = 1'b1;
    soc_qready_i   = 1'b0;
    soc_resp_i     = '0;
    soc_pvalid_i   = 1'b0;
    cur_row        = '0;
    hold_left      = 0;
    reads_issued   = 0;
    reads_returned = 0;
    repeat (3) @(posedge clk_i);
    #10;
    rst_n_i = 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_value("data_pvalid_o", 0, data_pvalid_o);
      check_value("soc_qvalid_o", 0, soc_qvalid_o);
    end
    for (int i = 0; i < NumRows; i++) begin
      row = table_rows[i];
      @(posedge clk_i);
      #10;
      cur_row        = row;
      data_q_i.addr  = row.addr;
      data_q_i.write = row.write;
      data_q_i.data  = row.data;
      data_q_i.strb  = row.strb;
      data_q_i.id    = '0;
      data_qvalid_i  = 1'b1;
      @(negedge clk_i);
      while (!data_qready_o) @(negedge clk_i);
      record_accept(row);
    end
    @(posedge clk_i);
    #10;
    data_qvalid_i = 1'b0;
    while (exp_q.size() != 0 || soc_jobs.size() != 0 || soc_pvalid_i) @(negedge clk_i);
    repeat (5) @(negedge clk_i);
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- project.f
rtl/shim_pkg.sv
rtl/reorder_buffer.sv
rtl/addr_demux.sv
rtl/tcdm_bank.sv
rtl/tcdm_shim.sv
rtl/shim_subsystem.sv
bench/tb_shim_subsystem.sv

//--- Bender.yml
package:
  name: shim_subsystem

sources:
  # Design, package first
  - rtl/shim_pkg.sv
  - rtl/reorder_buffer.sv
  - rtl/addr_demux.sv
  - rtl/tcdm_bank.sv
  - rtl/tcdm_shim.sv
  - rtl/shim_subsystem.sv

  # Testbench, top module tb_shim_subsystem
  - target: test
    files:
      - bench/tb_shim_subsystem.sv
